/* src/cmdq_pkg.sv */
package cmdq_pkg;

    // scratchpad and payload sizing
    localparam int ADDR_W = 4;                  // 16 scratchpad entries
    localparam int DATA_W = 16;                 // one data word
    localparam int TAG_W  = 4;                  // host tag, echoed in the response

    // command opcodes
    typedef enum logic [1:0] {
        OP_WRITE = 2'b00,                       // store data at addr
        OP_READ  = 2'b01,                       // return word at addr
        OP_ADD   = 2'b10                        // return old word, store old + data
    } op_e;                                     // 2'b11 unused, dropped by the executor

    // command as pushed by the host, 26 bits
    typedef struct packed {
        op_e               op;                  // what to do
        logic [TAG_W-1:0]  tag;                 // copied into the response
        logic [ADDR_W-1:0] addr;                // scratchpad index
        logic [DATA_W-1:0] data;                // write value or addend
    } cmd_t;

    // response popped by the host, 20 bits
    typedef struct packed {
        logic [TAG_W-1:0]  tag;                 // tag of the originating command
        logic [DATA_W-1:0] data;                // word as it was before the command
    } rsp_t;

endpackage

/* src/sync_fifo.sv */
`timescale 1ns/10ps

// show-ahead synchronous FIFO, any depth >= 1
// head entry is on data_o whenever empty_o is low
module sync_fifo #(
    parameter int  DEPTH = 4,                   // number of entries, need not be a power of two
    parameter type T     = logic [7:0]          // payload type
) (
    input  logic clk,                           // clock
    input  logic rst_n,                         // async reset, pointers only
    input  logic push_i,                        // write strobe, only while not full
    input  logic pop_i,                         // read strobe, only while not empty
    input  T     data_i,                        // write data
    output logic full_o,                        // no free entry
    output logic empty_o,                       // no valid entry
    output T     data_o                         // head entry, no read latency
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;    // index bits
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DEPTH - 1); // index before wrap

    // elaboration guard on the depth
    if (DEPTH < 1) begin : g_bad_depth
        $error("sync_fifo needs DEPTH >= 1, got %0d", DEPTH);
    end

    logic [IDX_W:0] wr_ptr, wr_ptr_nxt;         // msb is the wrap bit
    logic [IDX_W:0] rd_ptr, rd_ptr_nxt;         // msb is the wrap bit
    logic [IDX_W-1:0] wr_idx;                   // storage index of the next write
    logic [IDX_W-1:0] rd_idx;                   // storage index of the head

    T mem [DEPTH];                              // payload storage

    // step a pointer by one entry
    // index returns to zero after LAST_IDX and the wrap bit toggles there
    function automatic logic [IDX_W:0] ptr_step(input logic [IDX_W:0] ptr);
        logic [IDX_W:0] nxt;
        if (ptr[IDX_W-1:0] == LAST_IDX) begin
            nxt = {~ptr[IDX_W], {IDX_W{1'b0}}}; // wrap, flip msb
        end else begin
            nxt = ptr + 1'b1;                   // plain increment
        end
        return nxt;
    endfunction

    assign wr_idx = wr_ptr[IDX_W-1:0];
    assign rd_idx = rd_ptr[IDX_W-1:0];

    // next pointer values
    always_comb begin
        wr_ptr_nxt = wr_ptr;                    // hold by default
        rd_ptr_nxt = rd_ptr;
        if (push_i) begin
            wr_ptr_nxt = ptr_step(wr_ptr);      // advance on push
        end
        if (pop_i) begin
            rd_ptr_nxt = ptr_step(rd_ptr);      // advance on pop
        end
    end

    // pointer registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;                       // empty after reset
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr_nxt;
            rd_ptr <= rd_ptr_nxt;
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_idx] <= data_i;              // lands at the write index
        end
    end

    // show-ahead read, head straight from storage
    assign data_o = mem[rd_idx];

    // status flags
    assign empty_o = (wr_ptr == rd_ptr);        // same index, same lap
    assign full_o  = (wr_idx == rd_idx)         // same index
                   & (wr_ptr[IDX_W] != rd_ptr[IDX_W]); // writer one lap ahead

    // writer must respect full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o
    ) else $error("sync_fifo push while full");

    // reader must respect empty
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o
    ) else $error("sync_fifo pop while empty");

    // pointer scheme never reports both
    a_not_full_and_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(full_o && empty_o)
    ) else $error("sync_fifo full and empty at once");

endmodule

/* src/cmd_exec.sv */
`timescale 1ns/10ps

// in-order command executor with a 16-word scratchpad
// one command per cycle, stalls only on a response command with no response space
module cmd_exec (
    input  logic             clk,               // clock
    input  logic             rst_n,             // async reset, clears scratchpad
    input  logic             cmd_empty_i,       // command FIFO empty
    input  cmdq_pkg::cmd_t   cmd_i,             // command FIFO head
    output logic             cmd_pop_o,         // consume head this edge
    input  logic             rsp_full_i,        // response FIFO full
    output logic             rsp_push_o,        // push response this edge
    output cmdq_pkg::rsp_t   rsp_o              // response payload
);

    import cmdq_pkg::*;

    localparam int SP_WORDS = 1 << ADDR_W;      // scratchpad entries

    logic [DATA_W-1:0] spad [SP_WORDS];         // scratchpad storage
    logic [DATA_W-1:0] old_word;                // word at head addr before the edge
    logic [DATA_W-1:0] new_word;                // word to store
    logic              needs_rsp;               // head produces a response
    logic              stores;                  // head modifies the scratchpad
    logic              issue;                   // head executes this cycle
    logic              spad_we;                 // scratchpad write enable

    // decode the head
    always_comb begin
        needs_rsp = 1'b0;
        stores    = 1'b0;
        new_word  = old_word;                   // read keeps the word
        case (cmd_i.op)
            OP_WRITE: begin
                stores   = 1'b1;
                new_word = cmd_i.data;          // plain store
            end
            OP_READ: begin
                needs_rsp = 1'b1;               // old word goes back
            end
            OP_ADD: begin
                needs_rsp = 1'b1;
                stores    = 1'b1;
                new_word  = old_word + cmd_i.data; // wraps mod 2^DATA_W
            end
            default: begin
                needs_rsp = 1'b0;               // unused opcode, popped and dropped
                stores    = 1'b0;
            end
        endcase
    end

    assign old_word = spad[cmd_i.addr];         // combinational read at head addr

    // issue when there is a head and, if it answers, room for the answer
    assign issue      = !cmd_empty_i && (!needs_rsp || !rsp_full_i);
    assign cmd_pop_o  = issue;                  // one strobe per command
    assign rsp_push_o = issue && needs_rsp;     // writes never push
    assign spad_we    = issue && stores;

    // response carries the tag and the pre-edge word
    assign rsp_o = rsp_t'{tag: cmd_i.tag, data: old_word};

    // scratchpad update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SP_WORDS; i++) begin
                spad[i] <= '0;                  // all words start at zero
            end
        end else if (spad_we) begin
            spad[cmd_i.addr] <= new_word;       // data or sum
        end
    end

    // a response only ever comes from a popped command
    a_push_needs_pop: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_push_o |-> cmd_pop_o
    ) else $error("cmd_exec response pushed without a pop");

    // response FIFO back-pressure honoured
    a_no_push_rsp_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_push_o |-> !rsp_full_i
    ) else $error("cmd_exec push while response FIFO full");

    // command FIFO never underflows
    a_no_pop_cmd_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_pop_o |-> !cmd_empty_i
    ) else $error("cmd_exec pop while command FIFO empty");

endmodule

/* src/cmdq_top.sv */
`timescale 1ns/10ps

// command queue subsystem
// host -> command FIFO -> executor -> response FIFO -> host
module cmdq_top #(
    parameter int CMD_DEPTH = 6,                // command FIFO entries
    parameter int RSP_DEPTH = 3                 // response FIFO entries
) (
    input  logic           clk,                 // clock
    input  logic           rst_n,               // async reset, active low
    input  logic           cmd_push_i,          // host push strobe
    input  cmdq_pkg::cmd_t cmd_i,               // host command
    output logic           cmd_full_o,          // no room for a command
    input  logic           rsp_pop_i,           // host pop strobe
    output cmdq_pkg::rsp_t rsp_o,               // response head
    output logic           rsp_empty_o          // no response waiting
);

    import cmdq_pkg::*;

    // command FIFO to executor
    logic cmd_empty;                            // no command at the head
    cmd_t cmd_head;                             // head command, valid when not empty
    logic cmd_pop;                              // executor consumes head

    // executor to response FIFO
    logic rsp_push;                             // executor pushes a response
    rsp_t rsp_data;                             // response payload
    logic rsp_full;                             // response FIFO has no room

    // command queue
    sync_fifo #(
        .DEPTH (CMD_DEPTH),
        .T     (cmd_t)
    ) u_cmd_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (cmd_push_i),                  // straight from the host
        .pop_i   (cmd_pop),
        .data_i  (cmd_i),
        .full_o  (cmd_full_o),                  // straight back to the host
        .empty_o (cmd_empty),
        .data_o  (cmd_head)
    );

    // executor and scratchpad
    cmd_exec u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_empty_i (cmd_empty),
        .cmd_i       (cmd_head),
        .cmd_pop_o   (cmd_pop),
        .rsp_full_i  (rsp_full),                // back-pressure from the host side
        .rsp_push_o  (rsp_push),
        .rsp_o       (rsp_data)
    );

    // response queue
    sync_fifo #(
        .DEPTH (RSP_DEPTH),
        .T     (rsp_t)
    ) u_rsp_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (rsp_push),
        .pop_i   (rsp_pop_i),                   // host pop
        .data_i  (rsp_data),
        .full_o  (rsp_full),
        .empty_o (rsp_empty_o),                 // host sees empty directly
        .data_o  (rsp_o)                        // show-ahead head to host
    );

endmodule

/* verif/cmdq_tb.sv */
`timescale 1ns/10ps

// testbench for cmdq_top, random host traffic against a scratchpad model
module cmdq_tb;

    import cmdq_pkg::*;

    localparam int CMD_DEPTH     = 6;               // same as the top default
    localparam int RSP_DEPTH     = 3;               // same as the top default
    localparam int N_RANDOM      = 240;             // laps both FIFOs many times
    localparam int PUSH_TIMEOUT  = 200;             // cycles to get one command accepted
    localparam int FULL_TIMEOUT  = 100;             // cycles to see cmd_full_o rise
    localparam int DRAIN_TIMEOUT = 600;             // cycles to empty the response queue

    logic clk;
    logic rst_n;
    logic cmd_push_i;
    cmd_t cmd_i;
    logic cmd_full_o;
    logic rsp_pop_i;
    rsp_t rsp_o;
    logic rsp_empty_o;

    integer            seed = 87909;                // fixed seed
    logic [DATA_W-1:0] model_mem [1 << ADDR_W];     // expected scratchpad
    rsp_t              exp_q [$];                   // responses still owed, in order
    logic              push_now;                    // push driven for the current cycle
    logic              pop_now;                     // pop driven for the current cycle
    logic [TAG_W-1:0]  next_tag;                    // running tag, makes reordering visible
    int                n_rsp_cmds;                  // reads and adds sent
    int                n_rsp_seen;                  // responses popped and checked

    cmdq_top #(
        .CMD_DEPTH (CMD_DEPTH),
        .RSP_DEPTH (RSP_DEPTH)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_push_i  (cmd_push_i),
        .cmd_i       (cmd_i),
        .cmd_full_o  (cmd_full_o),
        .rsp_pop_i   (rsp_pop_i),
        .rsp_o       (rsp_o),
        .rsp_empty_o (rsp_empty_o)
    );

    always #20 clk = ~clk;                          // 40 ns period

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rsp(input rsp_t exp, input rsp_t act);
        if (act.tag !== exp.tag) begin
            $display("[ERROR] rsp_o.tag expected 0x%h got 0x%h", exp.tag, act.tag);
            abort_run();
        end
        if (act.data !== exp.data) begin
            $display("[ERROR] rsp_o.data expected 0x%h got 0x%h (tag 0x%h)",
                     exp.data, act.data, exp.tag);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic cmd_t make_cmd(input op_e op, input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data);
        cmd_t c;
        c.op     = op;
        c.tag    = next_tag;
        c.addr   = addr;
        c.data   = data;
        next_tag = next_tag + 1'b1;                 // wraps, order still checked
        return c;
    endfunction

    function automatic cmd_t random_cmd();
        int unsigned pick;
        op_e         op;
        pick = $unsigned($random(seed)) % 3;        // never the unused opcode
        op   = (pick == 0) ? OP_WRITE : ((pick == 1) ? OP_READ : OP_ADD);
        return make_cmd(op, ADDR_W'($random(seed)), DATA_W'($random(seed)));
    endfunction

    // scratchpad model, applied in push order
    task automatic apply_model(input cmd_t c);
        logic [DATA_W-1:0] old;
        old = model_mem[c.addr];
        case (c.op)
            OP_WRITE: model_mem[c.addr] = c.data;
            OP_READ: begin
                exp_q.push_back(rsp_t'{tag: c.tag, data: old});
                n_rsp_cmds++;
            end
            OP_ADD: begin
                exp_q.push_back(rsp_t'{tag: c.tag, data: old});
                model_mem[c.addr] = old + c.data;   // 16-bit wrap
                n_rsp_cmds++;
            end
            default: ;                              // not generated
        endcase
    endtask

    // one clock: check the pop of the cycle just ended, then drive the next one
    // flags seen here belong to that cycle, so no push or pop two cycles in a row
    task automatic step_cycle(input logic try_push, input cmd_t c, input logic pop_en,
                              output logic pushed);
        rsp_t exp;
        logic pop_ok;
        @(posedge clk);
        if (!rsp_empty_o && exp_q.size() == 0) begin
            $display("a response with tag 0x%h is queued but none is owed", rsp_o.tag);
            abort_run();
        end
        if (pop_now) begin
            exp = exp_q.pop_front();
            check_rsp(exp, rsp_o);                  // head during the pop cycle
            n_rsp_seen++;
        end
        pop_ok = !rsp_empty_o && !pop_now;
        pushed = try_push && !cmd_full_o && !push_now;
        if (pushed) begin
            apply_model(c);
        end
        push_now = pushed;
        pop_now  = pop_en && pop_ok && (($random(seed) & 1) != 0);
        cmd_push_i <= pushed;
        cmd_i      <= c;
        rsp_pop_i  <= pop_now;
    endtask

    task automatic send_cmd(input cmd_t c, input logic pop_en);
        logic pushed;
        int   waited;
        pushed = 1'b0;
        waited = 0;
        while (!pushed) begin
            if (waited == PUSH_TIMEOUT) begin
                $display("timeout: command with tag 0x%h was never accepted", c.tag);
                abort_run();
            end
            step_cycle(($random(seed) & 1) != 0, c, pop_en, pushed);  // random push bit
            waited++;
        end
    endtask

    task automatic drain_responses();
        logic pushed;
        int   waited;
        waited = 0;
        while (exp_q.size() != 0 || pop_now) begin
            if (waited == DRAIN_TIMEOUT) begin
                $display("timeout: %0d responses never arrived", exp_q.size());
                abort_run();
            end
            step_cycle(1'b0, '0, 1'b1, pushed);
            waited++;
        end
    endtask

    // reads with pops held: response FIFO fills, then the command FIFO
    task automatic fill_with_backpressure();
        cmd_t c;
        logic pushed;
        int   waited;
        int   n_pushed;
        waited   = 0;
        n_pushed = 0;
        drain_responses();
        c = make_cmd(OP_READ, ADDR_W'($random(seed)), '0);
        while (!cmd_full_o) begin
            if (waited == FULL_TIMEOUT) begin
                $display("timeout: cmd_full_o never rose while responses were held");
                abort_run();
            end
            step_cycle(1'b1, c, 1'b0, pushed);
            if (pushed) begin
                n_pushed++;
                c = make_cmd(OP_READ, ADDR_W'($random(seed)), '0);
            end
            waited++;
        end
        check_count("reads accepted before cmd_full_o", CMD_DEPTH + RSP_DEPTH, n_pushed);
        repeat (4) begin
            step_cycle(1'b1, c, 1'b0, pushed);      // stall must hold
            check_flag("cmd_full_o", 1'b1, cmd_full_o);
            check_flag("rsp_empty_o", 1'b0, rsp_empty_o);
        end
        drain_responses();                          // order and data still exact
    endtask

    initial begin
        logic pushed;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_push_i = 1'b0;
        cmd_i      = '0;
        rsp_pop_i  = 1'b0;
        push_now   = 1'b0;
        pop_now    = 1'b0;
        next_tag   = '0;
        n_rsp_cmds = 0;
        n_rsp_seen = 0;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            model_mem[a] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("cmd_full_o", 1'b0, cmd_full_o);
        check_flag("rsp_empty_o", 1'b1, rsp_empty_o);

        for (int a = 0; a < (1 << ADDR_W); a++) begin  // all zero after reset
            send_cmd(make_cmd(OP_READ, ADDR_W'(a), '0), 1'b1);
        end
        drain_responses();

        for (int a = 0; a < (1 << ADDR_W); a++) begin  // writes, then reads back
            send_cmd(make_cmd(OP_WRITE, ADDR_W'(a), DATA_W'($random(seed))), 1'b1);
        end
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            send_cmd(make_cmd(OP_READ, ADDR_W'(a), '0), 1'b1);
        end
        drain_responses();

        send_cmd(make_cmd(OP_WRITE, 4'h3, 16'hfff0), 1'b1);  // add that overflows
        send_cmd(make_cmd(OP_ADD, 4'h3, 16'h0025), 1'b1);
        send_cmd(make_cmd(OP_READ, 4'h3, '0), 1'b1);
        for (int i = 0; i < 8; i++) begin
            send_cmd(make_cmd(OP_ADD, ADDR_W'(i), DATA_W'($random(seed))), 1'b1);
            send_cmd(make_cmd(OP_READ, ADDR_W'(i), '0), 1'b1);
        end
        drain_responses();

        fill_with_backpressure();

        for (int i = 0; i < N_RANDOM; i++) begin
            send_cmd(random_cmd(), 1'b1);
        end
        drain_responses();

        repeat (4) begin
            step_cycle(1'b0, '0, 1'b1, pushed);
        end
        check_flag("rsp_empty_o", 1'b1, rsp_empty_o);
        check_flag("cmd_full_o", 1'b0, cmd_full_o);
        check_count("responses received", n_rsp_cmds, n_rsp_seen);
        $display("All checks passed");
        $finish;
    end

endmodule

/* tb.f */
src/cmdq_pkg.sv
src/sync_fifo.sv
src/cmd_exec.sv
src/cmdq_top.sv
verif/cmdq_tb.sv

/* Bender.yml */
# command queue subsystem with scratchpad executor

package:
  name: cmdq

dependencies: {}

sources:
  # design, package first
  - files:
      - src/cmdq_pkg.sv
      - src/sync_fifo.sv
      - src/cmd_exec.sv
      - src/cmdq_top.sv

  # testbench, top module cmdq_tb
  - target: test
    files:
      - verif/cmdq_tb.sv
